// File: rtl/mem_pkg.sv
package mem_pkg;

        localparam int DEF_DEPTH     = 1024;
        localparam int DEF_ADDR_WAIT = 1;
        localparam int DEF_DATA_LAT  = 2;

        // Memory opcode carried from execute
        typedef enum logic [3:0] {
                MOP_NONE,
                MOP_LD_B,
                MOP_LD_BU,
                MOP_LD_H,
                MOP_LD_HU,
                MOP_LD_W,
                MOP_ST_B,
                MOP_ST_H,
                MOP_ST_W
        } mem_op_e;

        typedef enum logic [2:0] {
                MS_IDLE,
                MS_ADDR,
                MS_DATA,
                MS_DONE,
                MS_DRAIN
        } mem_state_e;

        typedef struct packed {
                logic        valid;
                logic [31:0] pc;
                mem_op_e     op;
                logic        gr_we;
                logic [4:0]  waddr;
                logic [31:0] alu_result;
                logic [31:0] store_value;
                logic        ale;
        } ex_to_mem_t;

        typedef struct packed {
                logic        valid;
                logic [31:0] pc;
                logic        gr_we;
                logic [4:0]  waddr;
                logic [31:0] wdata;
                logic        excepted;
                logic [31:0] badv;
        } mem_to_wb_t;

        // Bypass toward decode
        typedef struct packed {
                logic        valid;
                logic [4:0]  addr;
                logic [31:0] data;
        } fwd_t;

        typedef struct packed {
                logic        req;
                logic        wr;
                logic [1:0]  size;
                logic [3:0]  wstrb;
                logic [31:0] addr;
                logic [31:0] wdata;
        } sram_req_t;

        typedef struct packed {
                logic        addr_ok;
                logic        data_ok;
                logic [31:0] rdata;
        } sram_rsp_t;

endpackage

// File: rtl/mem_store_align.sv
module mem_store_align (
        input  mem_pkg::mem_op_e op,
        input  logic [31:0]      addr,
        input  logic [31:0]      value,
        output logic [3:0]       wstrb,
        output logic [31:0]      wdata,
        output logic [1:0]       size
);

        always_comb begin
                case (op)
                mem_pkg::MOP_ST_B: begin
                        wstrb = 4'b0001 << addr[1:0];
                        wdata = {4{value[7:0]}};
                end
                mem_pkg::MOP_ST_H: begin
                        wstrb = addr[1] ? 4'b1100 : 4'b0011;
                        wdata = {2{value[15:0]}};
                end
                mem_pkg::MOP_ST_W: begin
                        wstrb = 4'b1111;
                        wdata = value;
                end
                default: begin
                        // Loads and non-memory ops write nothing
                        wstrb = 4'b0000;
                        wdata = value;
                end
                endcase
        end

        // Access size, shared by loads and stores
        always_comb begin
                case (op)
                mem_pkg::MOP_LD_B,
                mem_pkg::MOP_LD_BU,
                mem_pkg::MOP_ST_B: size = 2'd0;
                mem_pkg::MOP_LD_H,
                mem_pkg::MOP_LD_HU,
                mem_pkg::MOP_ST_H: size = 2'd1;
                default:           size = 2'd2;
                endcase
        end

endmodule

// File: rtl/mem_load_extend.sv
module mem_load_extend (
        input  mem_pkg::mem_op_e op,
        input  logic [1:0]       addr_lo,
        input  logic [31:0]      rdata,
        output logic [31:0]      result
);

        logic [31:0] shifted;
        logic [7:0]  byte_lane;
        logic [15:0] half_lane;

        // Bring the addressed lane down to bit 0
        assign shifted   = rdata >> {addr_lo, 3'b000};
        assign byte_lane = shifted[7:0];
        assign half_lane = addr_lo[1] ? rdata[31:16] : rdata[15:0];

        always_comb begin
                case (op)
                mem_pkg::MOP_LD_B: begin
                        result = {{24{byte_lane[7]}}, byte_lane};
                end
                mem_pkg::MOP_LD_BU: begin
                        result = {24'b0, byte_lane};
                end
                mem_pkg::MOP_LD_H: begin
                        result = {{16{half_lane[15]}}, half_lane};
                end
                mem_pkg::MOP_LD_HU: begin
                        result = {16'b0, half_lane};
                end
                default: begin
                        result = rdata;
                end
                endcase
        end

endmodule

// File: rtl/mem_stage.sv
module mem_stage (
        input  logic                clk,
        input  logic                rst,
        input  mem_pkg::ex_to_mem_t ex_in,
        input  logic                flush,
        input  logic                wb_allowin,
        output logic                mem_allowin,
        input  mem_pkg::sram_rsp_t  rsp,
        output mem_pkg::sram_req_t  req,
        output mem_pkg::fwd_t       fwd,
        output mem_pkg::mem_to_wb_t wb_out
);

        mem_pkg::mem_state_e state;
        mem_pkg::mem_state_e state_nxt;
        mem_pkg::ex_to_mem_t cur;
        logic                accept;
        logic                holding;
        logic                done;
        logic                cur_load;
        logic                cur_store;
        logic                in_mem;
        logic [31:0]         load_word;
        logic [31:0]         load_result;
        logic [31:0]         result;
        logic [3:0]          st_wstrb;
        logic [31:0]         st_wdata;
        logic [1:0]          acc_size;

        assign cur_load  = cur.op inside {mem_pkg::MOP_LD_B, mem_pkg::MOP_LD_BU,
                                          mem_pkg::MOP_LD_H, mem_pkg::MOP_LD_HU,
                                          mem_pkg::MOP_LD_W};
        assign cur_store = cur.op inside {mem_pkg::MOP_ST_B, mem_pkg::MOP_ST_H,
                                          mem_pkg::MOP_ST_W};

        // Misaligned accesses never reach the bus
        assign in_mem = (ex_in.op != mem_pkg::MOP_NONE) & ~ex_in.ale;

        assign done    = state == mem_pkg::MS_DONE;
        assign holding = state inside {mem_pkg::MS_ADDR, mem_pkg::MS_DATA, mem_pkg::MS_DONE};

        assign mem_allowin = ~flush & ((state == mem_pkg::MS_IDLE) | (done & wb_allowin));
        assign accept      = ex_in.valid & mem_allowin;

        always_comb begin
                state_nxt = state;
                if (flush) begin
                        // An accepted address still owes one data_ok
                        if ((state == mem_pkg::MS_ADDR & rsp.addr_ok) |
                            (state == mem_pkg::MS_DATA & ~rsp.data_ok) |
                            (state == mem_pkg::MS_DRAIN & ~rsp.data_ok)) begin
                                state_nxt = mem_pkg::MS_DRAIN;
                        end else begin
                                state_nxt = mem_pkg::MS_IDLE;
                        end
                end else if (accept) begin
                        state_nxt = in_mem ? mem_pkg::MS_ADDR : mem_pkg::MS_DONE;
                end else begin
                        case (state)
                        mem_pkg::MS_ADDR: begin
                                if (rsp.addr_ok) begin
                                        state_nxt = mem_pkg::MS_DATA;
                                end
                        end
                        mem_pkg::MS_DATA: begin
                                if (rsp.data_ok) begin
                                        state_nxt = mem_pkg::MS_DONE;
                                end
                        end
                        mem_pkg::MS_DONE: begin
                                if (wb_allowin) begin
                                        state_nxt = mem_pkg::MS_IDLE;
                                end
                        end
                        mem_pkg::MS_DRAIN: begin
                                if (rsp.data_ok) begin
                                        state_nxt = mem_pkg::MS_IDLE;
                                end
                        end
                        default: begin
                                state_nxt = state;
                        end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= mem_pkg::MS_IDLE;
                end else begin
                        state <= state_nxt;
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        cur <= ex_in;
                end
                if (state == mem_pkg::MS_DATA && rsp.data_ok) begin
                        load_word <= rsp.rdata;
                end
        end

        mem_store_align u_store_align (
                .op    (cur.op),
                .addr  (cur.alu_result),
                .value (cur.store_value),
                .wstrb (st_wstrb),
                .wdata (st_wdata),
                .size  (acc_size)
        );

        assign req.req   = state == mem_pkg::MS_ADDR;
        assign req.wr    = cur_store;
        assign req.size  = acc_size;
        assign req.wstrb = st_wstrb;
        assign req.addr  = cur.alu_result;
        assign req.wdata = st_wdata;

        mem_load_extend u_load_extend (
                .op      (cur.op),
                .addr_lo (cur.alu_result[1:0]),
                .rdata   (load_word),
                .result  (load_result)
        );

        assign result = (cur_load & ~cur.ale) ? load_result : cur.alu_result;

        // A load forwards only once its data is back
        assign fwd.valid = holding & cur.gr_we & ~cur.ale & (~cur_load | done);
        assign fwd.addr  = cur.waddr;
        assign fwd.data  = result;

        always_ff @(posedge clk) begin
                if (rst) begin
                        wb_out <= '0;
                end else if (wb_allowin) begin
                        if (done && !flush) begin
                                wb_out.valid    <= 1'b1;
                                wb_out.pc       <= cur.pc;
                                wb_out.gr_we    <= cur.gr_we & ~cur.ale;
                                wb_out.waddr    <= cur.waddr;
                                wb_out.wdata    <= result;
                                wb_out.excepted <= cur.ale;
                                wb_out.badv     <= cur.alu_result;
                        end else begin
                                wb_out <= '0;
                        end
                end
        end

endmodule

// File: rtl/data_sram.sv
module data_sram #(
        parameter int DEPTH     = mem_pkg::DEF_DEPTH,
        parameter int ADDR_WAIT = mem_pkg::DEF_ADDR_WAIT,
        parameter int DATA_LAT  = mem_pkg::DEF_DATA_LAT
) (
        input  logic               clk,
        input  logic               rst,
        input  mem_pkg::sram_req_t req,
        output mem_pkg::sram_rsp_t rsp
);

        localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(ADDR_WAIT + DATA_LAT + 2);

        logic [31:0]      mem [DEPTH];
        logic [IDX_W-1:0] idx;
        logic [CNT_W-1:0] wait_cnt;
        logic [CNT_W-1:0] lat_cnt;
        logic             busy;
        logic             accept;
        logic [31:0]      rdata_q;

        initial begin
                for (int i = 0; i < DEPTH; i++) begin
                        mem[i] = '0;
                end
        end

        // Word index wraps at DEPTH
        assign idx = IDX_W'(req.addr[31:2] % DEPTH);

        // Only one transaction in flight
        assign rsp.addr_ok = req.req & ~busy & (wait_cnt == CNT_W'(ADDR_WAIT));
        assign accept      = req.req & rsp.addr_ok;

        // DATA_LAT of at least 1 is assumed
        assign rsp.data_ok = busy & (lat_cnt == CNT_W'(DATA_LAT));
        assign rsp.rdata   = rdata_q;

        always_ff @(posedge clk) begin
                if (rst) begin
                        wait_cnt <= '0;
                end else if (req.req && !busy && !rsp.addr_ok) begin
                        wait_cnt <= wait_cnt + 1'b1;
                end else begin
                        wait_cnt <= '0;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy    <= 1'b0;
                        lat_cnt <= '0;
                end else if (accept) begin
                        busy    <= 1'b1;
                        lat_cnt <= CNT_W'(1);
                end else if (rsp.data_ok) begin
                        busy    <= 1'b0;
                end else if (busy) begin
                        lat_cnt <= lat_cnt + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        rdata_q <= mem[idx];
                        if (req.wr) begin
                                for (int b = 0; b < 4; b++) begin
                                        if (req.wstrb[b]) begin
                                                mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                                        end
                                end
                        end
                end
        end

endmodule

// File: rtl/mem_subsys_top.sv
module mem_subsys_top #(
        parameter int DEPTH     = mem_pkg::DEF_DEPTH,
        parameter int ADDR_WAIT = mem_pkg::DEF_ADDR_WAIT,
        parameter int DATA_LAT  = mem_pkg::DEF_DATA_LAT
) (
        input  logic                clk,
        input  logic                rst,
        input  mem_pkg::ex_to_mem_t ex_in,
        input  logic                flush,
        input  logic                wb_allowin,
        output logic                mem_allowin,
        output mem_pkg::fwd_t       fwd,
        output mem_pkg::mem_to_wb_t wb_out
);

        mem_pkg::sram_req_t req_bus;
        mem_pkg::sram_rsp_t rsp_bus;

        mem_stage u_mem_stage (
                .clk         (clk),
                .rst         (rst),
                .ex_in       (ex_in),
                .flush       (flush),
                .wb_allowin  (wb_allowin),
                .mem_allowin (mem_allowin),
                .rsp         (rsp_bus),
                .req         (req_bus),
                .fwd         (fwd),
                .wb_out      (wb_out)
        );

        data_sram #(
                .DEPTH     (DEPTH),
                .ADDR_WAIT (ADDR_WAIT),
                .DATA_LAT  (DATA_LAT)
        ) u_data_sram (
                .clk (clk),
                .rst (rst),
                .req (req_bus),
                .rsp (rsp_bus)
        );

endmodule

// File: test/mem_subsys_checker.sv
module mem_subsys_checker (
        input logic                clk,
        input logic                rst,
        input logic                flush,
        input logic                wb_allowin,
        input logic                mem_allowin,
        input mem_pkg::mem_state_e state,
        input mem_pkg::sram_req_t  req,
        input mem_pkg::sram_rsp_t  rsp,
        input mem_pkg::mem_to_wb_t wb_out
);

        logic outstanding;

        // One accepted address owes one data_ok
        always_ff @(posedge clk) begin
                if (rst) begin
                        outstanding <= 1'b0;
                end else if (req.req && rsp.addr_ok) begin
                        outstanding <= 1'b1;
                end else if (rsp.data_ok) begin
                        outstanding <= 1'b0;
                end
        end

        req_stable: assert property (@(posedge clk) disable iff (rst)
                (req.req && !rsp.addr_ok && !flush) |=> $stable(req))
                else $error("request changed before it was accepted");

        data_after_accept: assert property (@(posedge clk) disable iff (rst)
                rsp.data_ok |-> outstanding)
                else $error("data_ok with no accepted address");

        drain_blocks: assert property (@(posedge clk) disable iff (rst)
                (state == mem_pkg::MS_DRAIN) |-> (!mem_allowin && outstanding))
                else $error("stage open while draining, or draining with no data owed");

        wb_holds: assert property (@(posedge clk) disable iff (rst)
                !wb_allowin |=> $stable(wb_out))
                else $error("write-back record moved under back-pressure");

endmodule

bind mem_stage mem_subsys_checker chk (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .wb_allowin  (wb_allowin),
        .mem_allowin (mem_allowin),
        .state       (state),
        .req         (req),
        .rsp         (rsp),
        .wb_out      (wb_out)
);

// File: test/mem_subsys_tb.sv
module mem_subsys_tb;

        localparam int DEPTH     = mem_pkg::DEF_DEPTH;
        localparam int ADDR_WAIT = mem_pkg::DEF_ADDR_WAIT;
        localparam int DATA_LAT  = mem_pkg::DEF_DATA_LAT;
        localparam int NUM_INSTR = 400;
        localparam int PERIOD    = 100;

        logic                clk;
        logic                rst;
        mem_pkg::ex_to_mem_t ex_in;
        logic                flush;
        logic                wb_allowin;
        logic                mem_allowin;
        mem_pkg::fwd_t       fwd;
        mem_pkg::mem_to_wb_t wb_out;

        integer              seed;
        logic [31:0]         shadow [16];
        mem_pkg::mem_to_wb_t exp_q [$];
        mem_pkg::mem_to_wb_t fwd_q [$];
        logic                allow_at_edge;
        logic                held_load;

        mem_subsys_top #(
                .DEPTH     (DEPTH),
                .ADDR_WAIT (ADDR_WAIT),
                .DATA_LAT  (DATA_LAT)
        ) dut (
                .clk         (clk),
                .rst         (rst),
                .ex_in       (ex_in),
                .flush       (flush),
                .wb_allowin  (wb_allowin),
                .mem_allowin (mem_allowin),
                .fwd         (fwd),
                .wb_out      (wb_out)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #(PERIOD / 2) clk = ~clk;
                end
        end

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("error %s got %h expected %h", name, got, exp);
                        $display("Verification failed");
                        $fatal(1);
                end
        endtask

        // Expected write-back record; stores update the shadow memory
        function automatic mem_pkg::mem_to_wb_t reference_result(input mem_pkg::ex_to_mem_t e);
                mem_pkg::mem_to_wb_t r;
                logic [31:0]         word;
                logic [7:0]          b;
                logic [15:0]         h;
                int                  idx;
                idx   = e.alu_result[5:2];
                word  = shadow[idx];
                b     = word >> (8 * e.alu_result[1:0]);
                h     = e.alu_result[1] ? word[31:16] : word[15:0];
                r.valid    = 1'b1;
                r.pc       = e.pc;
                r.gr_we    = e.gr_we & ~e.ale;
                r.waddr    = e.waddr;
                r.wdata    = e.alu_result;
                r.excepted = e.ale;
                r.badv     = e.alu_result;
                if (!e.ale) begin
                        case (e.op)
                        mem_pkg::MOP_LD_B:  r.wdata = {{24{b[7]}}, b};
                        mem_pkg::MOP_LD_BU: r.wdata = {24'b0, b};
                        mem_pkg::MOP_LD_H:  r.wdata = {{16{h[15]}}, h};
                        mem_pkg::MOP_LD_HU: r.wdata = {16'b0, h};
                        mem_pkg::MOP_LD_W:  r.wdata = word;
                        mem_pkg::MOP_ST_B:  shadow[idx][8*e.alu_result[1:0] +: 8] = e.store_value[7:0];
                        mem_pkg::MOP_ST_H:  shadow[idx][16*e.alu_result[1] +: 16] = e.store_value[15:0];
                        mem_pkg::MOP_ST_W:  shadow[idx] = e.store_value;
                        default:            r.wdata = e.alu_result;
                        endcase
                end
                return r;
        endfunction

        function automatic mem_pkg::ex_to_mem_t random_instr(input logic [31:0] pc);
                mem_pkg::ex_to_mem_t e;
                logic [31:0]         u;
                u = $random(seed);
                e.valid       = 1'b1;
                e.pc          = pc;
                e.op          = mem_pkg::mem_op_e'(u[7:0] % 9);
                e.waddr       = u[12:8];
                e.ale         = 1'b0;
                e.store_value = $random(seed);
                e.alu_result  = {26'b0, u[21:16]};
                e.gr_we       = (e.op == mem_pkg::MOP_NONE) ? u[13] : (e.op < mem_pkg::MOP_ST_B);
                if (e.op inside {mem_pkg::MOP_LD_H, mem_pkg::MOP_LD_HU, mem_pkg::MOP_ST_H}) begin
                        e.alu_result[0] = 1'b0;
                end else if (e.op inside {mem_pkg::MOP_LD_W, mem_pkg::MOP_ST_W}) begin
                        e.alu_result[1:0] = 2'b00;
                end
                // Now and then a misaligned half or word access flagged by execute
                if (u[26:24] == 3'd0 && e.op inside {mem_pkg::MOP_LD_H, mem_pkg::MOP_ST_H,
                                                     mem_pkg::MOP_LD_W, mem_pkg::MOP_ST_W}) begin
                        e.alu_result[0] = 1'b1;
                        e.ale           = 1'b1;
                end
                return e;
        endfunction

        initial begin
                #((16 + NUM_INSTR * (ADDR_WAIT + DATA_LAT + 8)) * PERIOD);
                $display("Timeout: the stage stopped delivering instructions");
                $display("Verification failed");
                $fatal(1);
        end

        // Write-back and forwarding comparison, sampled mid-cycle
        initial begin
                mem_pkg::mem_to_wb_t e;
                allow_at_edge = 1'b0;
                forever begin
                        @(negedge clk);
                        if (!rst && allow_at_edge && wb_out.valid) begin
                                if (exp_q.size() == 0) begin
                                        $display("A write-back record appeared with none expected");
                                        $display("Verification failed");
                                        $fatal(1);
                                end
                                e = exp_q.pop_front();
                                check_value("wb_out.pc", wb_out.pc, e.pc);
                                check_value("wb_out.gr_we", wb_out.gr_we, e.gr_we);
                                check_value("wb_out.waddr", wb_out.waddr, e.waddr);
                                check_value("wb_out.wdata", wb_out.wdata, e.wdata);
                                check_value("wb_out.excepted", wb_out.excepted, e.excepted);
                                check_value("wb_out.badv", wb_out.badv, e.badv);
                                // The held instruction has moved on to write-back
                                if (fwd_q.size() != 0 && fwd_q[0].pc == e.pc) begin
                                        fwd_q.delete();
                                end
                        end
                        if (!rst) begin
                                if (fwd_q.size() == 0) begin
                                        if (fwd.valid) begin
                                                $display("Forwarding was valid with no instruction held");
                                                $display("Verification failed");
                                                $fatal(1);
                                        end
                                end else begin
                                        // A load forwards only once its data is back
                                        if (!held_load) begin
                                                check_value("fwd.valid", fwd.valid, fwd_q[0].gr_we);
                                        end
                                        if (fwd.valid) begin
                                                check_value("fwd.addr", fwd.addr, fwd_q[0].waddr);
                                                check_value("fwd.data", fwd.data, fwd_q[0].wdata);
                                        end
                                end
                        end
                        allow_at_edge = wb_allowin;
                end
        end

        initial begin
                logic                acc;
                int                  count;
                int                  stall;
                logic [31:0]         pc;
                mem_pkg::mem_to_wb_t r;
                seed       = 32'he49a0fc4;
                rst        = 1'b1;
                flush      = 1'b0;
                wb_allowin = 1'b1;
                ex_in      = '0;
                held_load  = 1'b0;
                count      = 0;
                stall      = 0;
                pc         = 32'h1c00_0000;
                for (int i = 0; i < 16; i++) begin
                        shadow[i] = '0;
                end
                repeat (16) @(posedge clk);
                #1;
                rst   = 1'b0;
                ex_in = random_instr(pc);
                while (count < NUM_INSTR) begin
                        @(negedge clk);
                        acc = ex_in.valid && mem_allowin;
                        @(posedge clk);
                        #1;
                        flush = 1'b0;
                        if (acc) begin
                                r = reference_result(ex_in);
                                exp_q.push_back(r);
                                fwd_q.delete();
                                fwd_q.push_back(r);
                                held_load = (ex_in.op inside {[mem_pkg::MOP_LD_B:mem_pkg::MOP_LD_W]})
                                            && !ex_in.ale;
                                count++;
                                pc    = pc + 4;
                                ex_in = random_instr(pc);
                                if ($random(seed) % 8 == 0) begin
                                        ex_in.valid = 1'b0;
                                end
                        end else if (!ex_in.valid) begin
                                ex_in.valid = 1'b1;
                        end
                        // Loads only, so a dropped access never touches memory
                        if (held_load && dut.u_mem_stage.state inside {mem_pkg::MS_ADDR,
                            mem_pkg::MS_DATA} && $random(seed) % 6 == 0) begin
                                flush     = 1'b1;
                                held_load = 1'b0;
                                void'(exp_q.pop_back());
                                fwd_q.delete();
                        end
                        if (stall > 0) begin
                                stall--;
                        end else if ($random(seed) % 8 == 0) begin
                                stall = 1 + ($unsigned($random(seed)) % 3);
                        end
                        wb_allowin = (stall == 0);
                end
                ex_in.valid = 1'b0;
                @(negedge clk);
                #(PERIOD / 2 + 1);
                flush       = 1'b0;
                wb_allowin  = 1'b1;
                while (exp_q.size() != 0) begin
                        @(posedge clk);
                end
                repeat (4) @(posedge clk);
                $display("Verification passed");
                $finish;
        end

endmodule

// File: sources.f
rtl/mem_pkg.sv
rtl/mem_store_align.sv
rtl/mem_load_extend.sv
rtl/mem_stage.sv
rtl/data_sram.sv
rtl/mem_subsys_top.sv
test/mem_subsys_checker.sv
test/mem_subsys_tb.sv
